/* design/vma_params.svh */
`ifndef VMA_PARAMS_SVH
`define VMA_PARAMS_SVH

// Address split, section over offset
`define VMA_SEC_W 5
`define VMA_OFF_W 18
`define VMA_W 23

// AD and EBUS word
`define WORD_W 36

// Microcode magic field
`define MAGIC_W 9

// Offsets below this are AC addresses
`define AC_LIMIT 16

`endif

/* design/vmaPkg.sv */
package vmaPkg;

  typedef enum logic [3:0] {
    CMD_NOP        = 4'd0,
    CMD_LOAD_AD    = 4'd1,
    CMD_LOAD_MAGIC = 4'd2,
    CMD_INC        = 4'd3,
    CMD_LOAD_PC    = 4'd4,
    CMD_HOLD       = 4'd5,
    CMD_DATAO_APR  = 4'd6,
    CMD_LOAD_PREV  = 4'd7,
    CMD_SET_SEC    = 4'd8,
    CMD_FETCH      = 4'd9
  } vmaCmd_t;

  // Section source used by SET_SEC
  typedef enum logic [1:0] {
    VMAX_KEEP     = 2'd0,
    VMAX_PC_SEC   = 2'd1,
    VMAX_PREV_SEC = 2'd2,
    VMAX_AD_SEC   = 2'd3
  } vmaxSel_t;

  typedef enum logic [2:0] {
    DIAG_PC      = 3'd0,
    DIAG_HELD    = 3'd1,
    DIAG_ADR_BRK = 3'd2,
    DIAG_VMA     = 3'd3,
    DIAG_PREV    = 3'd4,
    DIAG_FLAGS   = 3'd5
  } diagSel_t;

  typedef enum logic [1:0] {
    SRC_AD      = 2'd0,
    SRC_MAGIC   = 2'd1,
    SRC_SECTION = 2'd2
  } vmaSrc_t;

endpackage

/* design/vmaCtlIf.sv */
interface vmaCtlIf import vmaPkg::*; ();

  logic     loadVma;
  logic     incVma;
  vmaSrc_t  vmaSrc;
  vmaxSel_t vmaxSel;
  logic     loadPc;
  logic     loadHeld;
  logic     loadAdrBrk;
  logic     loadPrev;

  // Sequencer side
  modport seq (
    output loadVma, incVma, vmaSrc, vmaxSel,
    output loadPc, loadHeld, loadAdrBrk, loadPrev
  );

  // Counter, adder and register side
  modport data (
    input loadVma, incVma, vmaSrc, vmaxSel,
    input loadPc, loadHeld, loadAdrBrk, loadPrev
  );

endinterface

/* design/vmaSequencer.sv */
module vmaSequencer import vmaPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  vmaCmd_t  cmd,
  input  vmaxSel_t sec,
  output logic     busy,
  output logic     done,
  vmaCtlIf.seq     ctl
);

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SRC_PC = 2'd1,
    STEP   = 2'd2,
    LATCH  = 2'd3
  } seqState_t;

  seqState_t state;
  seqState_t stateNext;
  logic      loadVmaNext;
  logic      incVmaNext;
  vmaSrc_t   vmaSrcNext;
  vmaxSel_t  vmaxSelNext;
  logic      loadPcNext;
  logic      loadHeldNext;
  logic      loadAdrBrkNext;
  logic      loadPrevNext;

  // Strobes are decoded one cycle ahead and registered
  always_comb begin
    stateNext      = state;
    loadVmaNext    = 1'b0;
    incVmaNext     = 1'b0;
    vmaSrcNext     = SRC_AD;
    vmaxSelNext    = VMAX_KEEP;
    loadPcNext     = 1'b0;
    loadHeldNext   = 1'b0;
    loadAdrBrkNext = 1'b0;
    loadPrevNext   = 1'b0;
    case (state)
      IDLE: begin
        case (cmd)
          CMD_LOAD_AD: loadVmaNext = 1'b1;
          CMD_LOAD_MAGIC: begin
            loadVmaNext = 1'b1;
            vmaSrcNext  = SRC_MAGIC;
          end
          CMD_INC:       incVmaNext     = 1'b1;
          CMD_LOAD_PC:   loadPcNext     = 1'b1;
          CMD_HOLD:      loadHeldNext   = 1'b1;
          CMD_DATAO_APR: loadAdrBrkNext = 1'b1;
          CMD_LOAD_PREV: loadPrevNext   = 1'b1;
          CMD_SET_SEC: begin
            loadVmaNext = 1'b1;
            vmaSrcNext  = SRC_SECTION;
            vmaxSelNext = sec;
          end
          // First fetch step, VMA gets PC plus one
          CMD_FETCH: begin
            stateNext   = SRC_PC;
            loadVmaNext = 1'b1;
            vmaSrcNext  = SRC_MAGIC;
          end
          default: ;
        endcase
      end
      SRC_PC: begin
        stateNext  = STEP;
        loadPcNext = 1'b1;
      end
      STEP: begin
        stateNext    = LATCH;
        loadHeldNext = 1'b1;
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state          <= IDLE;
      ctl.loadVma    <= 1'b0;
      ctl.incVma     <= 1'b0;
      ctl.vmaSrc     <= SRC_AD;
      ctl.vmaxSel    <= VMAX_KEEP;
      ctl.loadPc     <= 1'b0;
      ctl.loadHeld   <= 1'b0;
      ctl.loadAdrBrk <= 1'b0;
      ctl.loadPrev   <= 1'b0;
    end else begin
      state          <= stateNext;
      ctl.loadVma    <= loadVmaNext;
      ctl.incVma     <= incVmaNext;
      ctl.vmaSrc     <= vmaSrcNext;
      ctl.vmaxSel    <= vmaxSelNext;
      ctl.loadPc     <= loadPcNext;
      ctl.loadHeld   <= loadHeldNext;
      ctl.loadAdrBrk <= loadAdrBrkNext;
      ctl.loadPrev   <= loadPrevNext;
    end
  end

  assign busy = (state != IDLE);
  assign done = (state == LATCH);

  // Done only at the end of a full fetch walk
  assert property (@(posedge clk) disable iff (!rstN)
    done |-> ($past(state) == STEP) && ($past(state, 2) == SRC_PC));

  assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({ctl.loadVma, ctl.incVma, ctl.loadPc, ctl.loadHeld,
              ctl.loadAdrBrk, ctl.loadPrev}));

endmodule

/* design/vmaCounter.sv */
`include "vma_params.svh"

module vmaCounter (
  input  logic             clk,
  input  logic             rstN,
  vmaCtlIf.data            ctl,
  input  logic [`VMA_W-1:0] nextVma,
  output logic [`VMA_W-1:0] vma
);

  localparam int VmaW = `VMA_W;
  localparam int OffW = `VMA_OFF_W;

  logic [VmaW-1:OffW] secQ;
  logic [OffW-1:0]    offQ;
  logic [OffW-1:0]    offInc;

  assign secQ = vma[VmaW-1:OffW];
  assign offQ = vma[OffW-1:0];

  // Wraps inside the section, never carries out
  assign offInc = offQ + 1'b1;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      vma <= '0;
    end else if (ctl.loadVma) begin
      vma <= nextVma;
    end else if (ctl.incVma) begin
      vma <= {secQ, offInc};
    end
  end

  // Section is local to the increment
  assert property (@(posedge clk) disable iff (!rstN)
    ctl.incVma && !ctl.loadVma |=> vma[VmaW-1:OffW] == $past(secQ));

endmodule

/* design/vmaAdder.sv */
`include "vma_params.svh"

module vmaAdder import vmaPkg::*; (
  vmaCtlIf.data                  ctl,
  input  logic [`WORD_W-1:0]    ad,
  input  logic [`MAGIC_W-1:0]   magic,
  input  logic [`VMA_W-1:0]     vma,
  input  logic [`VMA_W-1:0]     pc,
  input  logic [`VMA_SEC_W-1:0] prevSec,
  output logic [`VMA_W-1:0]     nextVma
);

  localparam int VmaW   = `VMA_W;
  localparam int OffW   = `VMA_OFF_W;
  localparam int SecW   = `VMA_SEC_W;
  localparam int MagicW = `MAGIC_W;

  logic [OffW-1:0] magicOff;
  logic [SecW-1:0] secIn;

  // PC offset plus magic, dropping the carry
  assign magicOff = pc[OffW-1:0] + {{(OffW - MagicW){1'b0}}, magic};

  always_comb begin
    case (ctl.vmaxSel)
      VMAX_KEEP:     secIn = vma[VmaW-1:OffW];
      VMAX_PC_SEC:   secIn = pc[VmaW-1:OffW];
      VMAX_PREV_SEC: secIn = prevSec;
      default:       secIn = ad[17:13];
    endcase
  end

  always_comb begin
    case (ctl.vmaSrc)
      SRC_MAGIC:   nextVma = {pc[VmaW-1:OffW], magicOff};
      SRC_SECTION: nextVma = {secIn, vma[OffW-1:0]};
      default:     nextVma = ad[VmaW-1:0];
    endcase
  end

endmodule

/* design/vmaRegs.sv */
`include "vma_params.svh"

module vmaRegs (
  input  logic                  clk,
  input  logic                  rstN,
  vmaCtlIf.data                 ctl,
  input  logic [`WORD_W-1:0]    ad,
  input  logic [`VMA_W-1:0]     vma,
  input  logic                  extended,
  output logic [`VMA_W-1:0]     pc,
  output logic [`VMA_W-1:0]     held,
  output logic [`VMA_W-1:0]     adrBrk,
  output logic [`VMA_SEC_W-1:0] prevSec,
  output logic                  acRef,
  output logic                  match
);

  localparam int VmaW = `VMA_W;
  localparam int OffW = `VMA_OFF_W;
  localparam int SecW = `VMA_SEC_W;

  logic [SecW-1:0] vmaSec;
  logic [OffW-1:0] vmaOff;
  logic            localRef;

  assign vmaSec = vma[VmaW-1:OffW];
  assign vmaOff = vma[OffW-1:0];

  // PC and HELD both copy the VMA
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc   <= '0;
      held <= '0;
    end else begin
      if (ctl.loadPc) begin
        pc <= vma;
      end
      if (ctl.loadHeld) begin
        held <= vma;
      end
    end
  end

  // Written by DATAO APR and previous-context load
  always_ff @(posedge clk) begin
    if (!rstN) begin
      adrBrk  <= '0;
      prevSec <= '0;
    end else begin
      if (ctl.loadAdrBrk) begin
        adrBrk <= ad[VmaW-1:0];
      end
      if (ctl.loadPrev) begin
        prevSec <= ad[17:13];
      end
    end
  end

  // Sections 0 and 1 count as local
  assign localRef = !extended || (vmaSec[SecW-1:1] == '0);
  assign acRef    = (vmaOff < `AC_LIMIT) && localRef;

  assign match = (adrBrk == vma);

endmodule

/* design/vmaDiagMux.sv */
`include "vma_params.svh"

module vmaDiagMux import vmaPkg::*; (
  input  logic                  diagRead,
  input  diagSel_t              diagSel,
  input  logic [`VMA_W-1:0]     pc,
  input  logic [`VMA_W-1:0]     held,
  input  logic [`VMA_W-1:0]     adrBrk,
  input  logic [`VMA_W-1:0]     vma,
  input  logic [`VMA_SEC_W-1:0] prevSec,
  input  logic                  acRef,
  input  logic                  match,
  output logic [`WORD_W-1:0]    ebusData,
  output logic                  ebusDriving
);

  localparam int WordW = `WORD_W;
  localparam int VmaW  = `VMA_W;
  localparam int SecW  = `VMA_SEC_W;
  localparam int OffW  = `VMA_OFF_W;

  logic [WordW-1:0] diagWord;
  logic [4:0]       flags;

  // Section-zero flags over match and AC_REF
  assign flags = {prevSec == '0, pc[VmaW-1:OffW] == '0, vma[VmaW-1:OffW] == '0,
                  match, acRef};

  always_comb begin
    case (diagSel)
      DIAG_PC:      diagWord = {{(WordW - VmaW){1'b0}}, pc};
      DIAG_HELD:    diagWord = {{(WordW - VmaW){1'b0}}, held};
      DIAG_ADR_BRK: diagWord = {{(WordW - VmaW){1'b0}}, adrBrk};
      DIAG_VMA:     diagWord = {{(WordW - VmaW){1'b0}}, vma};
      DIAG_PREV:    diagWord = {{(WordW - SecW){1'b0}}, prevSec};
      DIAG_FLAGS:   diagWord = {{(WordW - 5){1'b0}}, flags};
      default:      diagWord = '0;
    endcase
  end

  // Bus stays quiet unless read
  assign ebusData    = diagRead ? diagWord : '0;
  assign ebusDriving = diagRead;

endmodule

/* design/vmaTop.sv */
`include "vma_params.svh"

module vmaTop import vmaPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  vmaCmd_t             cmd,
  input  vmaxSel_t            sec,
  input  logic [`WORD_W-1:0]  ad,
  input  logic [`MAGIC_W-1:0] magic,
  input  logic                extended,
  input  logic                diagRead,
  input  diagSel_t            diagSel,
  output logic [`VMA_W-1:0]   vma,
  output logic [`VMA_W-1:0]   pc,
  output logic [`VMA_W-1:0]   held,
  output logic                acRef,
  output logic                match,
  output logic                busy,
  output logic                done,
  output logic [`WORD_W-1:0]  ebusData,
  output logic                ebusDriving
);

  logic [`VMA_W-1:0]     nextVma;
  logic [`VMA_W-1:0]     adrBrk;
  logic [`VMA_SEC_W-1:0] prevSec;
  logic [`MAGIC_W-1:0]   magicIn;

  vmaCtlIf ctl ();

  // Fetch steps PC by one regardless of the microcode field
  assign magicIn = busy ? {{(`MAGIC_W - 1){1'b0}}, 1'b1} : magic;

  vmaSequencer u_seq (
    .clk(clk), .rstN(rstN), .cmd(cmd), .sec(sec),
    .busy(busy), .done(done), .ctl(ctl.seq)
  );

  vmaCounter u_counter (
    .clk(clk), .rstN(rstN), .ctl(ctl.data), .nextVma(nextVma), .vma(vma)
  );

  vmaAdder u_adder (
    .ctl(ctl.data), .ad(ad), .magic(magicIn), .vma(vma), .pc(pc),
    .prevSec(prevSec), .nextVma(nextVma)
  );

  vmaRegs u_regs (
    .clk(clk), .rstN(rstN), .ctl(ctl.data), .ad(ad), .vma(vma),
    .extended(extended), .pc(pc), .held(held), .adrBrk(adrBrk),
    .prevSec(prevSec), .acRef(acRef), .match(match)
  );

  vmaDiagMux u_diag (
    .diagRead(diagRead), .diagSel(diagSel), .pc(pc), .held(held),
    .adrBrk(adrBrk), .vma(vma), .prevSec(prevSec), .acRef(acRef),
    .match(match), .ebusData(ebusData), .ebusDriving(ebusDriving)
  );

endmodule

/* sim/vmaTb.sv */
`include "vma_params.svh"

module vmaTb import vmaPkg::*; ();

  localparam int WordW = `WORD_W;
  localparam int VmaW  = `VMA_W;
  localparam int OffW  = `VMA_OFF_W;
  // Tests need about 200 cycles
  localparam int MaxCycles = 400;

  logic                clk;
  logic                rstN;
  vmaCmd_t             cmd;
  vmaxSel_t            sec;
  logic [WordW-1:0]    ad;
  logic [`MAGIC_W-1:0] magic;
  logic                extended;
  logic                diagRead;
  diagSel_t            diagSel;
  logic [VmaW-1:0]     vma;
  logic [VmaW-1:0]     pc;
  logic [VmaW-1:0]     held;
  logic                acRef;
  logic                match;
  logic                busy;
  logic                done;
  logic [WordW-1:0]    ebusData;
  logic                ebusDriving;

  logic [31:0]     rngState;
  int              cycles = 0;
  // Reference copies of the DUT registers
  logic [VmaW-1:0] expVma;
  logic [VmaW-1:0] expPc;
  logic [VmaW-1:0] expHeld;
  logic [VmaW-1:0] expAdrBrk;
  logic [4:0]      expPrev;

  vmaTop u_dut (
    .clk(clk), .rstN(rstN), .cmd(cmd), .sec(sec), .ad(ad), .magic(magic),
    .extended(extended), .diagRead(diagRead), .diagSel(diagSel),
    .vma(vma), .pc(pc), .held(held), .acRef(acRef), .match(match),
    .busy(busy), .done(done), .ebusData(ebusData), .ebusDriving(ebusDriving)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run went past %0d cycles", MaxCycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic compare(input logic [WordW-1:0] actual, input logic [WordW-1:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [WordW-1:0] randAd();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRand();
    lo = nextRand();
    return {hi[3:0], lo};
  endfunction

  // Offset steps by one, section untouched
  function automatic logic [VmaW-1:0] incOffset(input logic [VmaW-1:0] v);
    logic [OffW-1:0] off;
    off = v[OffW-1:0] + 18'd1;
    return {v[VmaW-1:OffW], off};
  endfunction

  function automatic logic [VmaW-1:0] addMagic(input logic [VmaW-1:0] p, input logic [8:0] m);
    logic [OffW-1:0] off;
    off = p[OffW-1:0] + {9'd0, m};
    return {p[VmaW-1:OffW], off};
  endfunction

  function automatic logic acRefRule(input logic [VmaW-1:0] v, input logic ext);
    return (v[OffW-1:0] < OffW'(`AC_LIMIT)) && (!ext || v[VmaW-1:OffW] < 5'd2);
  endfunction

  function automatic logic [4:0] expectedFlags();
    return {expPrev == 5'd0, expPc[VmaW-1:OffW] == 5'd0, expVma[VmaW-1:OffW] == 5'd0,
            expAdrBrk == expVma, acRefRule(expVma, extended)};
  endfunction

  // Command strobe for one cycle, result checked after the update edge
  task automatic runCmd(input vmaCmd_t c, input logic [WordW-1:0] adValue);
    @(posedge clk);
    cmd <= c;
    ad  <= adValue;
    @(posedge clk);
    cmd <= CMD_NOP;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic checkRegs();
    compare(WordW'(vma), WordW'(expVma), "VMA");
    compare(WordW'(pc), WordW'(expPc), "PC");
    compare(WordW'(held), WordW'(expHeld), "HELD");
  endtask

  task automatic readDiag(input diagSel_t s, input logic [WordW-1:0] expected,
                          input string what);
    @(posedge clk);
    diagRead <= 1'b1;
    diagSel  <= s;
    @(negedge clk);
    compare(WordW'(ebusDriving), WordW'(1), "ebusDriving");
    compare(ebusData, expected, what);
    @(posedge clk);
    diagRead <= 1'b0;
  endtask

  task automatic checkReset();
    @(negedge clk);
    compare(WordW'(busy), '0, "busy after reset");
    compare(WordW'(done), '0, "done after reset");
    compare(WordW'(ebusDriving), '0, "ebusDriving after reset");
    checkRegs();
  endtask

  task automatic loadAndIncrement();
    logic [WordW-1:0] a;
    for (int i = 0; i < 3; i++) begin
      a = randAd();
      // Top of the offset range
      if (i == 2) a[VmaW-1:0] = {5'h0A, 18'h3FFFF};
      runCmd(CMD_LOAD_AD, a);
      expVma = a[VmaW-1:0];
      checkRegs();
      runCmd(CMD_INC, a);
      expVma = incOffset(expVma);
      checkRegs();
    end
  endtask

  task automatic fetchSequence();
    logic [WordW-1:0] a;
    int               busyCycles;
    a = randAd();
    runCmd(CMD_LOAD_AD, a);
    runCmd(CMD_LOAD_PC, a);
    expVma = a[VmaW-1:0];
    expPc  = expVma;
    checkRegs();
    @(posedge clk);
    cmd   <= CMD_FETCH;
    magic <= 9'h055;
    // Arrives while busy and must be dropped
    @(posedge clk);
    cmd <= CMD_LOAD_AD;
    ad  <= ~a;
    busyCycles = 0;
    @(negedge clk);
    while (!done && busyCycles < 8) begin
      if (busy) busyCycles++;
      @(posedge clk);
      cmd <= CMD_NOP;
      @(negedge clk);
    end
    if (!done) begin
      $display("FETCH did not raise done within 8 cycles");
      $display("RESULT: FAIL");
      $fatal(1, "fetch stuck");
    end
    if (busy) busyCycles++;
    compare(WordW'(busyCycles), WordW'(3), "busy cycles of FETCH");
    @(posedge clk);
    @(negedge clk);
    compare(WordW'(busy), '0, "busy after FETCH");
    compare(WordW'(done), '0, "done after FETCH");
    expVma  = incOffset(expPc);
    expPc   = expVma;
    expHeld = expVma;
    checkRegs();
  endtask

  task automatic loadMagic();
    logic [WordW-1:0] a;
    logic [31:0]      r;
    logic [8:0]       m;
    for (int i = 0; i < 4; i++) begin
      a = randAd();
      r = nextRand();
      m = r[8:0];
      if (i == 0) begin
        // Carry out of the offset is lost
        a[OffW-1:0] = 18'h3FFF0;
        m = 9'h1FF;
      end
      runCmd(CMD_LOAD_AD, a);
      runCmd(CMD_LOAD_PC, a);
      expVma = a[VmaW-1:0];
      expPc  = expVma;
      @(posedge clk);
      magic <= m;
      runCmd(CMD_LOAD_MAGIC, a);
      expVma = addMagic(expPc, m);
      checkRegs();
    end
  endtask

  task automatic acRefAndMatch();
    logic [WordW-1:0] a;
    logic [WordW-1:0] b;
    for (int i = 0; i < 8; i++) begin
      a = randAd();
      if (i % 4 < 2) a[OffW-1:4] = '0;
      if (i % 3 == 0) a[VmaW-1:OffW+1] = '0;
      b = (i % 2 == 0) ? a : randAd();
      runCmd(CMD_DATAO_APR, b);
      expAdrBrk = b[VmaW-1:0];
      runCmd(CMD_LOAD_AD, a);
      expVma = a[VmaW-1:0];
      for (int e = 0; e < 2; e++) begin
        @(posedge clk);
        extended <= e[0];
        @(negedge clk);
        compare(WordW'(acRef), WordW'(acRefRule(expVma, e[0])), "acRef");
        compare(WordW'(match), WordW'(expAdrBrk == expVma), "match");
      end
    end
  endtask

  task automatic sectionAndDiag();
    logic [WordW-1:0] a;
    logic [4:0]       newSec;
    a = randAd();
    a[VmaW-1:OffW] = 5'h13;
    runCmd(CMD_LOAD_AD, a);
    runCmd(CMD_LOAD_PC, a);
    runCmd(CMD_HOLD, a);
    expVma  = a[VmaW-1:0];
    expPc   = expVma;
    expHeld = expVma;
    a = randAd();
    runCmd(CMD_DATAO_APR, a);
    expAdrBrk = a[VmaW-1:0];
    a = randAd();
    a[17:13] = 5'h07;
    runCmd(CMD_LOAD_PREV, a);
    expPrev = a[17:13];
    a = randAd();
    a[VmaW-1:OffW] = 5'h1C;
    // AC offset, so the flags word is not all zero
    a[OffW-1:4] = '0;
    runCmd(CMD_LOAD_AD, a);
    expVma = a[VmaW-1:0];
    checkRegs();
    for (int s = 0; s < 4; s++) begin
      a = randAd();
      // Section zero from AD on the last pass
      if (s == 3) a[17:13] = 5'h00;
      @(posedge clk);
      sec <= vmaxSel_t'(s);
      runCmd(CMD_SET_SEC, a);
      case (s)
        0:       newSec = expVma[VmaW-1:OffW];
        1:       newSec = expPc[VmaW-1:OffW];
        2:       newSec = expPrev;
        default: newSec = a[17:13];
      endcase
      expVma = {newSec, expVma[OffW-1:0]};
      checkRegs();
    end
    readDiag(DIAG_PC, WordW'(expPc), "diag PC");
    readDiag(DIAG_HELD, WordW'(expHeld), "diag HELD");
    readDiag(DIAG_ADR_BRK, WordW'(expAdrBrk), "diag address break");
    readDiag(DIAG_VMA, WordW'(expVma), "diag VMA");
    readDiag(DIAG_PREV, WordW'(expPrev), "diag previous section");
    readDiag(DIAG_FLAGS, WordW'(expectedFlags()), "diag flags");
    // Bus quiet with diagRead low
    @(posedge clk);
    diagSel <= DIAG_PC;
    @(negedge clk);
    compare(ebusData, '0, "ebusData while not read");
    compare(WordW'(ebusDriving), '0, "ebusDriving while not read");
  endtask

  initial begin
    rngState  = 32'd42923;
    rstN      = 1'b0;
    cmd       = CMD_NOP;
    sec       = VMAX_KEEP;
    ad        = '0;
    magic     = '0;
    extended  = 1'b0;
    diagRead  = 1'b0;
    diagSel   = DIAG_PC;
    expVma    = '0;
    expPc     = '0;
    expHeld   = '0;
    expAdrBrk = '0;
    expPrev   = '0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    checkReset();
    loadAndIncrement();
    fetchSequence();
    loadMagic();
    acRefAndMatch();
    sectionAndDiag();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+design
design/vmaPkg.sv
design/vmaCtlIf.sv
design/vmaSequencer.sv
design/vmaCounter.sv
design/vmaAdder.sv
design/vmaRegs.sv
design/vmaDiagMux.sv
design/vmaTop.sv
sim/vmaTb.sv

/* Makefile */
# Verilator flow for the VMA testbench

SIM = obj_dir/vmaSim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module vmaTb

sim:
	verilator --binary --timing --assert -f all.f --top-module vmaTb -o vmaSim
	./$(SIM)

clean:
	rm -rf obj_dir
